/* src.f */
dla_isa_pkg.sv
dla_dp_pkg.sv
instr_fetch.sv
instr_fifo.sv
ctrl_seq.sv
bus_loader.sv
operand_bufs.sv
scale_unit.sv
dla_top.sv
dla_top_chk.sv
tb_dla_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the dla_top testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dla_top -f src.f -o sim_dla

./obj_dir/sim_dla 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0

/* tb_dla_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dla_top;

  localparam int FIFO_DEPTH   = 8;
  localparam int IMEM_AW      = 16;
  localparam int DONE_TIMEOUT = 3000; // cycles per program

  logic                 clk = 1'b0;
  logic                 rst = 1'b1;
  logic                 acc_enable = 1'b0;
  logic [IMEM_AW-1:0]   instr_addr;
  logic                 instr_rd_en;
  logic [63:0]          instr_data = '0;
  logic [15:0]          feature_addr;
  logic                 feature_rd_en;
  logic [127:0]         feature_data = '0;
  logic [15:0]          w_addr;
  logic                 w_rd_en;
  logic [63:0]          w_data = '0;
  dla_dp_pkg::result_t  scaled;
  logic                 scaled_valid;
  logic                 done;

  // external memories
  logic [63:0]  imem [256];
  logic [127:0] fmem [256];
  logic [63:0]  wmem [256];

  // what the program leaves in the on-chip buffers
  logic [127:0] sh_feat   [256];
  logic [15:0]  sh_scaler [256];
  logic [31:0]  sh_bias   [256];
  logic [2:0]   cur_lane;
  logic [4:0]   cur_shift;

  dla_dp_pkg::result_t exp_q [$];
  dla_dp_pkg::result_t got_q [$];
  logic [7:0]          pc;
  logic [31:0]         rng = 32'h669f_8ccc;
  int                  errors = 0;
  string               test_name;

  always #4 clk = ~clk; // 8 ns period

  dla_top #(.FIFO_DEPTH(FIFO_DEPTH), .IMEM_AW(IMEM_AW)) i_dut (
    .clk(clk), .i_rst(rst), .i_acc_enable(acc_enable),
    .o_instr_addr(instr_addr), .o_instr_rd_en(instr_rd_en), .i_instr_data(instr_data),
    .o_feature_addr(feature_addr), .o_feature_rd_en(feature_rd_en),
    .i_feature_data(feature_data),
    .o_w_addr(w_addr), .o_w_rd_en(w_rd_en), .i_w_data(w_data),
    .o_scaled_feature(scaled), .o_scaled_valid(scaled_valid), .o_done(done)
  );

  ////////////////////////////////////////////////////////////
  // memory models with data one cycle after rd_en
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (instr_rd_en === 1'b1)
      instr_data <= imem[instr_addr[7:0]];
    if (feature_rd_en === 1'b1)
      feature_data <= fmem[feature_addr[7:0]];
    if (w_rd_en === 1'b1)
      w_data <= wmem[w_addr[7:0]];
  end

  always @(posedge clk) begin
    if (scaled_valid === 1'b1)
      got_q.push_back(scaled); // results in arrival order
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // (f * s + b) >>> shift with the sum wrapped to 32 bits first
  function automatic dla_dp_pkg::result_t expect_result(input logic [127:0] feat,
      input logic [15:0] s, input logic [31:0] b, input logic [2:0] lane, input logic [4:0] sh);
    logic signed [15:0] f;
    logic signed [31:0] prod;
    logic signed [31:0] sum;
    f    = feat[lane*16 +: 16];
    prod = f * $signed(s);
    sum  = prod + $signed(b);
    return sum >>> sh;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_result(input string name, input dla_dp_pkg::result_t exp_v,
      input dla_dp_pkg::result_t act_v);
    if (act_v !== exp_v) begin
      $display("** Error %s: expected %h, actual %h", name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp_v, input int act_v);
    if (act_v != exp_v) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp_v, act_v);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // program builders that also track the expected buffer state
  ////////////////////////////////////////////////////////////
  task automatic emit(input dla_isa_pkg::instr_u w);
    imem[pc] = w;
    pc = pc + 8'd1;
  endtask

  task automatic op_load(input dla_isa_pkg::opcode_e op, input logic tgt,
      input logic [15:0] src, input logic [7:0] dst, input logic [7:0] cnt);
    dla_isa_pkg::instr_u w;
    int k;
    w = '0;
    w.xfer.opcode   = op;
    w.xfer.target   = tgt;
    w.xfer.src_addr = src;
    w.xfer.dst_addr = dst;
    w.xfer.count    = cnt;
    emit(w);
    for (k = 0; k <= int'(cnt); k++) begin // count 0 is one entry
      if (op == dla_isa_pkg::OP_LOAD_F)
        sh_feat[dst + 8'(k)] = fmem[src[7:0] + 8'(k)];
      else if (!tgt)
        sh_scaler[dst + 8'(k)] = wmem[src[7:0] + 8'(k)][15:0];
      else
        sh_bias[dst + 8'(k)] = wmem[src[7:0] + 8'(k)][31:0];
    end
  endtask

  task automatic op_config(input logic [2:0] lane, input logic [4:0] sh);
    dla_isa_pkg::instr_u w;
    w = '0;
    w.cfg.opcode   = dla_isa_pkg::OP_CONFIG;
    w.cfg.lane_sel = lane;
    w.cfg.shift    = sh;
    emit(w);
    cur_lane  = lane;
    cur_shift = sh;
  endtask

  task automatic op_scale(input logic [7:0] dst, input logic [7:0] cnt);
    dla_isa_pkg::instr_u w;
    logic [7:0] idx;
    int k;
    w = '0;
    w.xfer.opcode   = dla_isa_pkg::OP_SCALE;
    w.xfer.dst_addr = dst;
    w.xfer.count    = cnt;
    emit(w);
    for (k = 0; k <= int'(cnt); k++) begin
      idx = dst + 8'(k);
      exp_q.push_back(expect_result(sh_feat[idx], sh_scaler[idx], sh_bias[idx],
                                    cur_lane, cur_shift));
    end
  endtask

  task automatic op_halt();
    dla_isa_pkg::instr_u w;
    w = '0;
    w.cfg.opcode = dla_isa_pkg::OP_HALT;
    emit(w);
  endtask

  ////////////////////////////////////////////////////////////
  // test flow
  ////////////////////////////////////////////////////////////
  task automatic fill_data();
    int a;
    int j;
    for (a = 0; a < 256; a++) begin
      for (j = 0; j < 4; j++) begin // four 32-bit chunks per feature word
        fmem[a][j*32 +: 32] = rng;
        rng = xorshift32(rng);
      end
      for (j = 0; j < 2; j++) begin
        wmem[a][j*32 +: 32] = rng;
        rng = xorshift32(rng);
      end
    end
  endtask

  task automatic begin_test(input string name);
    dla_isa_pkg::instr_u w;
    int a;
    test_name = name;
    @(posedge clk);
    rst        <= 1'b1;
    acc_enable <= 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (a = 0; a < 256; a++) begin // unused words halt with their address in the pad
      w = '0;
      w.cfg.opcode = dla_isa_pkg::OP_HALT;
      w.cfg.pad    = 52'(a);
      imem[a]      = w;
    end
    pc = '0;
    exp_q.delete();
    got_q.delete();
  endtask

  task automatic run_program();
    int n;
    int i;
    @(posedge clk);
    acc_enable <= 1'b1;
    n = 0;
    while (done !== 1'b1 && n < DONE_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (done !== 1'b1) begin
      $display("%s: timed out waiting for o_done after %0d cycles", test_name, n);
      errors++;
    end
    acc_enable <= 1'b0;
    check_count({test_name, " result count"}, exp_q.size(), got_q.size());
    for (i = 0; i < exp_q.size() && i < got_q.size(); i++)
      check_result($sformatf("%s[%0d]", test_name, i), exp_q[i], got_q[i]);
  endtask

  task automatic test_reset_idle();
    int n;
    int bad;
    begin_test("reset_idle");
    bad = 0;
    for (n = 0; n < 20; n++) begin
      @(posedge clk);
      if (instr_rd_en !== 1'b0 || feature_rd_en !== 1'b0 || w_rd_en !== 1'b0 ||
          scaled_valid !== 1'b0 || done !== 1'b0)
        bad++;
    end
    if (bad != 0) begin
      $display("reset_idle: an output went active while the accelerator was disabled");
      errors++;
    end
  endtask

  task automatic load_common(input logic [7:0] dst, input logic [7:0] cnt,
      input logic [7:0] src);
    op_load(dla_isa_pkg::OP_LOAD_F, 1'b0, {8'h00, src}, dst, cnt);
    op_load(dla_isa_pkg::OP_LOAD_P, 1'b0, {8'h00, src}, dst, cnt);         // scaler
    op_load(dla_isa_pkg::OP_LOAD_P, 1'b1, {8'h00, src + 8'h40}, dst, cnt); // bias
  endtask

  task automatic test_basic_scale();
    begin_test("basic_scale");
    load_common(8'd0, 8'd3, 8'h00);
    op_config(3'd0, 5'd0);
    op_scale(8'd0, 8'd3);
    op_halt();
    run_program();
  endtask

  task automatic test_config_effect();
    begin_test("config_effect");
    load_common(8'd0, 8'd3, 8'h00);
    op_config(3'd0, 5'd0);
    op_scale(8'd0, 8'd3);
    op_config(3'd5, 5'd4); // new lane and shift
    op_scale(8'd0, 8'd3);
    op_halt();
    run_program();
  endtask

  task automatic test_backpressure();
    int i;
    begin_test("fifo_backpressure");
    load_common(8'd16, 8'd7, 8'h10);
    for (i = 0; i < 8; i++) begin // 20 words in all and deeper than the fifo
      op_config(3'(i), 5'(i * 3));
      op_scale(8'(16 + i), 8'd0);
    end
    op_halt();
    run_program();
  endtask

  task automatic test_random_data();
    begin_test("random_data");
    fill_data();
    load_common(8'd32, 8'd15, 8'h20);
    op_config(rng[2:0], rng[12:8]);
    rng = xorshift32(rng);
    op_scale(8'd32, 8'd15);
    op_halt();
    run_program();
  endtask

  initial begin
    fill_data();
    test_reset_idle();
    test_basic_scale();
    test_config_effect();
    test_backpressure();
    test_random_data();
    repeat (2) @(posedge clk);
    $display("tests done, errors: %0d", errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* dla_top_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module dla_top_chk (
  input wire       clk,
  input wire       i_rst,
  input wire [2:0] i_req,  // scale, par, feat
  input wire [2:0] i_ack,
  input wire       i_scaled_valid,
  input wire       i_done,
  input wire       i_instr_rd_en,
  input wire       i_feature_rd_en,
  input wire       i_w_rd_en
);

  ////////////////////////////////////////////////////////////
  // four-phase order, all three pairs at once
  ////////////////////////////////////////////////////////////
  a_one_req: assert property (@(posedge clk) disable iff (i_rst) $onehot0(i_req))
    else $error("more than one unit requested at once");
  a_ack_rise: assert property (@(posedge clk) disable iff (i_rst)
    (i_ack & ~$past(i_ack) & ~i_req) == 3'b000)
    else $error("ack rose without a request");
  a_req_fall: assert property (@(posedge clk) disable iff (i_rst)
    (~i_req & $past(i_req) & ~i_ack) == 3'b000)
    else $error("req dropped before ack");
  a_ack_fall: assert property (@(posedge clk) disable iff (i_rst)
    (~i_ack & $past(i_ack) & i_req) == 3'b000)
    else $error("ack dropped while req still high");
  a_req_rise: assert property (@(posedge clk) disable iff (i_rst)
    (i_req & ~$past(i_req) & i_ack) == 3'b000)
    else $error("req rose before ack was released");

  // no new results once halted
  a_no_valid_after_done: assert property (@(posedge clk) disable iff (i_rst)
    $past(i_done) |-> !$rose(i_scaled_valid))
    else $error("scaled valid rose after done");

  a_rd_en_reset: assert property (@(posedge clk)
    (i_rst && $past(i_rst)) |-> !(i_instr_rd_en || i_feature_rd_en || i_w_rd_en))
    else $error("read enable high during reset");

endmodule

bind dla_top dla_top_chk protocol_chk (
  .clk(clk), .i_rst(i_rst),
  .i_req({req_scale, req_par, req_feat}),
  .i_ack({ack_scale, ack_par, ack_feat}),
  .i_scaled_valid(o_scaled_valid), .i_done(o_done),
  .i_instr_rd_en(o_instr_rd_en), .i_feature_rd_en(o_feature_rd_en),
  .i_w_rd_en(o_w_rd_en)
);

`default_nettype wire

/* dla_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dla_top #(
  parameter int FIFO_DEPTH = 8,
  parameter int IMEM_AW    = 16
) (
  input  wire                                  clk,
  input  wire                                  i_rst,
  input  wire                                  i_acc_enable,
  output logic [IMEM_AW-1:0]                   o_instr_addr,
  output logic                                 o_instr_rd_en,
  input  wire  [dla_isa_pkg::INSTR_W-1:0]      i_instr_data,
  output logic [dla_dp_pkg::EXT_AW-1:0]        o_feature_addr,
  output logic                                 o_feature_rd_en,
  input  wire  [dla_dp_pkg::FBUS_W-1:0]        i_feature_data,
  output logic [dla_dp_pkg::EXT_AW-1:0]        o_w_addr,
  output logic                                 o_w_rd_en,
  input  wire  [dla_dp_pkg::WBUS_W-1:0]        i_w_data,
  output dla_dp_pkg::result_t                  o_scaled_feature,
  output logic                                 o_scaled_valid,
  output logic                                 o_done
);

  logic                                run;
  logic                                push, pop, empty;
  logic [dla_isa_pkg::INSTR_W-1:0]     push_data;
  logic [$clog2(FIFO_DEPTH+1)-1:0]     level;
  dla_isa_pkg::instr_u                 pop_data;
  dla_dp_pkg::job_t                    job;  // shared by all three units
  dla_dp_pkg::cfg_t                    cfg;
  logic                                cfg_wr;
  logic                                req_feat, ack_feat;
  logic                                req_par, ack_par;
  logic                                req_scale, ack_scale;
  dla_dp_pkg::buf_wr_t                 feat_wr, par_wr;
  logic [dla_dp_pkg::BUF_AW-1:0]       rd_idx;
  logic [dla_dp_pkg::FBUS_W-1:0]       feat_rd;
  logic [dla_dp_pkg::SCALER_W-1:0]     scaler_rd;
  logic [dla_dp_pkg::BIAS_W-1:0]       bias_rd;

  assign run = i_acc_enable && !o_done; // fetch stops once halted

  ////////////////////////////////////////////////////////////
  // instruction side
  ////////////////////////////////////////////////////////////
  instr_fetch #(.FIFO_DEPTH(FIFO_DEPTH), .IMEM_AW(IMEM_AW)) instruction_fetcher (
    .clk(clk), .i_rst(i_rst), .i_run(run), .i_fifo_level(level),
    .o_instr_addr(o_instr_addr), .o_instr_rd_en(o_instr_rd_en),
    .i_instr_data(i_instr_data), .o_push(push), .o_push_data(push_data)
  );

  instr_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) instruction_queue (
    .clk(clk), .i_rst(i_rst), .i_push(push), .i_push_data(push_data),
    .i_pop(pop), .o_pop_data(pop_data), .o_empty(empty), .o_level(level)
  );

  ctrl_seq sequencer (
    .clk(clk), .i_rst(i_rst), .i_acc_enable(i_acc_enable), .i_empty(empty),
    .i_instr(pop_data), .o_pop(pop), .o_job(job),
    .o_req_feat(req_feat), .i_ack_feat(ack_feat),
    .o_req_par(req_par), .i_ack_par(ack_par),
    .o_req_scale(req_scale), .i_ack_scale(ack_scale),
    .o_cfg_wr(cfg_wr), .o_cfg(cfg), .o_done(o_done)
  );

  ////////////////////////////////////////////////////////////
  // loaders, buffers and scaling
  ////////////////////////////////////////////////////////////
  bus_loader #(.BUS_W(dla_dp_pkg::FBUS_W)) feature_loader (
    .clk(clk), .i_rst(i_rst), .i_req(req_feat), .o_ack(ack_feat), .i_job(job),
    .o_rd_addr(o_feature_addr), .o_rd_en(o_feature_rd_en),
    .i_rd_data(i_feature_data), .o_wr(feat_wr)
  );

  bus_loader #(.BUS_W(dla_dp_pkg::WBUS_W)) param_loader (
    .clk(clk), .i_rst(i_rst), .i_req(req_par), .o_ack(ack_par), .i_job(job),
    .o_rd_addr(o_w_addr), .o_rd_en(o_w_rd_en),
    .i_rd_data(i_w_data), .o_wr(par_wr)
  );

  operand_bufs buffers (
    .clk(clk), .i_feat_wr(feat_wr), .i_par_wr(par_wr), .i_rd_addr(rd_idx),
    .o_feat(feat_rd), .o_scaler(scaler_rd), .o_bias(bias_rd)
  );

  scale_unit scaler (
    .clk(clk), .i_rst(i_rst), .i_cfg_wr(cfg_wr), .i_cfg(cfg),
    .i_req(req_scale), .o_ack(ack_scale), .i_job(job), .o_rd_addr(rd_idx),
    .i_feat(feat_rd), .i_scaler(scaler_rd), .i_bias(bias_rd),
    .o_result(o_scaled_feature), .o_valid(o_scaled_valid)
  );

endmodule

`default_nettype wire

/* scale_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module scale_unit (
  input  wire                                  clk,
  input  wire                                  i_rst,
  input  wire                                  i_cfg_wr,
  input  dla_dp_pkg::cfg_t                     i_cfg,
  input  wire                                  i_req,
  output logic                                 o_ack,
  input  dla_dp_pkg::job_t                     i_job,
  output logic [dla_dp_pkg::BUF_AW-1:0]        o_rd_addr,
  input  wire  [dla_dp_pkg::FBUS_W-1:0]        i_feat,
  input  wire  [dla_dp_pkg::SCALER_W-1:0]      i_scaler,
  input  wire  [dla_dp_pkg::BIAS_W-1:0]        i_bias,
  output dla_dp_pkg::result_t                  o_result,
  output logic                                 o_valid
);

  dla_dp_pkg::cfg_t                                     cfg_q; // lane select and shift
  logic                                                 start, busy, issue, last_issue;
  logic                                                 v1, v2, l1, l2, l3;
  logic [dla_dp_pkg::CNT_W-1:0]                         left;
  logic [dla_dp_pkg::TN-1:0][dla_dp_pkg::FEATURE_W-1:0] lanes;
  logic signed [dla_dp_pkg::RESULT_W-1:0]               prod_q;
  logic signed [dla_dp_pkg::BIAS_W-1:0]                 bias_q;
  logic signed [dla_dp_pkg::RESULT_W-1:0]               sum;

  assign start      = i_req && !busy && !o_ack;
  assign last_issue = issue && (left == '0);
  assign lanes      = i_feat; // lane 0 in the low bits
  assign sum        = prod_q + bias_q; // wraps at 32 bits

  ////////////////////////////////////////////////////////////
  // issue, valid and last flags along the three stages
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_rst) begin
      cfg_q   <= '0;
      busy    <= 1'b0;
      issue   <= 1'b0;
      {v1, v2, o_valid} <= 3'b000;
      {l1, l2, l3}      <= 3'b000;
      o_ack   <= 1'b0;
    end else begin
      if (i_cfg_wr)
        cfg_q <= i_cfg;
      if (start) begin
        busy  <= 1'b1;
        issue <= 1'b1;
      end else if (last_issue) begin
        issue <= 1'b0;
      end
      v1      <= issue;      // buffer read
      l1      <= last_issue;
      v2      <= v1;         // multiply
      l2      <= l1;
      o_valid <= v2;         // add and shift
      l3      <= l2;
      if (l3) begin
        o_ack <= 1'b1;       // one cycle past the last result
        busy  <= 1'b0;
      end else if (!i_req) begin
        o_ack <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // index walk and arithmetic
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (start) begin
      o_rd_addr <= i_job.dst_addr;
      left      <= i_job.count;
    end else if (issue) begin
      o_rd_addr <= o_rd_addr + 1'b1;
      left      <= left - 1'b1;
    end
    prod_q   <= $signed(lanes[cfg_q.lane_sel]) * $signed(i_scaler);
    bias_q   <= i_bias;
    o_result <= sum >>> cfg_q.shift; // arithmetic shift
  end

endmodule

`default_nettype wire

/* operand_bufs.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_bufs (
  input  wire                                  clk,
  input  dla_dp_pkg::buf_wr_t                  i_feat_wr,
  input  dla_dp_pkg::buf_wr_t                  i_par_wr,
  input  wire  [dla_dp_pkg::BUF_AW-1:0]        i_rd_addr,
  output logic [dla_dp_pkg::FBUS_W-1:0]        o_feat,
  output logic [dla_dp_pkg::SCALER_W-1:0]      o_scaler,
  output logic [dla_dp_pkg::BIAS_W-1:0]        o_bias
);

  localparam int AW = dla_dp_pkg::BUF_AW;

  logic [dla_dp_pkg::FBUS_W-1:0]   feat_mem   [dla_dp_pkg::BUF_DEPTH];
  logic [dla_dp_pkg::SCALER_W-1:0] scaler_mem [dla_dp_pkg::BUF_DEPTH];
  logic [dla_dp_pkg::BIAS_W-1:0]   bias_mem   [dla_dp_pkg::BUF_DEPTH];

  // write side, feature loader ignores the routing bit
  always_ff @(posedge clk) begin
    if (i_feat_wr.en)
      feat_mem[i_feat_wr.addr[AW-1:0]] <= i_feat_wr.data;
    if (i_par_wr.en && !i_par_wr.addr[AW]) // scaler
      scaler_mem[i_par_wr.addr[AW-1:0]] <= i_par_wr.data[dla_dp_pkg::SCALER_W-1:0];
    if (i_par_wr.en && i_par_wr.addr[AW])  // bias
      bias_mem[i_par_wr.addr[AW-1:0]] <= i_par_wr.data[dla_dp_pkg::BIAS_W-1:0];
  end

  // one registered read, same index into all three
  always_ff @(posedge clk) begin
    o_feat   <= feat_mem[i_rd_addr];
    o_scaler <= scaler_mem[i_rd_addr];
    o_bias   <= bias_mem[i_rd_addr];
  end

endmodule

`default_nettype wire

/* bus_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_loader #(
  parameter int BUS_W = 128
) (
  input  wire                                clk,
  input  wire                                i_rst,
  input  wire                                i_req,
  output logic                               o_ack,
  input  dla_dp_pkg::job_t                   i_job,
  output logic [dla_dp_pkg::EXT_AW-1:0]      o_rd_addr,
  output logic                               o_rd_en,
  input  wire  [BUS_W-1:0]                   i_rd_data,
  output dla_dp_pkg::buf_wr_t                o_wr
);

  logic                              start;
  logic                              busy;
  logic                              last_rd; // final read of the burst
  logic                              wr_q;    // read data arriving now
  logic                              last_q;
  logic                              target_q;
  logic [dla_dp_pkg::CNT_W-1:0]      left;
  logic [dla_dp_pkg::BUF_AW-1:0]     wr_idx;

  assign start   = i_req && !busy && !o_ack;
  assign last_rd = o_rd_en && (left == '0);

  always_comb begin
    o_wr.en   = wr_q;
    o_wr.addr = {target_q, wr_idx}; // msb picks scaler or bias
    o_wr.data = dla_dp_pkg::FBUS_W'(i_rd_data);
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      busy    <= 1'b0;
      o_rd_en <= 1'b0;
      wr_q    <= 1'b0;
      last_q  <= 1'b0;
      o_ack   <= 1'b0;
    end else begin
      if (start) begin
        busy    <= 1'b1;
        o_rd_en <= 1'b1;
      end else if (last_rd) begin
        o_rd_en <= 1'b0;
      end
      wr_q   <= o_rd_en;
      last_q <= last_rd;
      if (last_q) begin
        o_ack <= 1'b1; // cycle after the last write
        busy  <= 1'b0;
      end else if (!i_req) begin
        o_ack <= 1'b0;
      end
    end
  end

  // burst counters
  always_ff @(posedge clk) begin
    if (start) begin
      o_rd_addr <= i_job.src_addr;
      left      <= i_job.count; // count 0 means one word
      wr_idx    <= i_job.dst_addr;
      target_q  <= i_job.target;
    end else begin
      if (o_rd_en) begin
        o_rd_addr <= o_rd_addr + 1'b1;
        left      <= left - 1'b1;
      end
      if (wr_q)
        wr_idx <= wr_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* ctrl_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_seq (
  input  wire                  clk,
  input  wire                  i_rst,
  input  wire                  i_acc_enable,
  input  wire                  i_empty,
  input  dla_isa_pkg::instr_u  i_instr,
  output logic                 o_pop,
  output dla_dp_pkg::job_t     o_job,
  output logic                 o_req_feat,
  input  wire                  i_ack_feat,
  output logic                 o_req_par,
  input  wire                  i_ack_par,
  output logic                 o_req_scale,
  input  wire                  i_ack_scale,
  output logic                 o_cfg_wr,
  output dla_dp_pkg::cfg_t     o_cfg,
  output logic                 o_done
);

  typedef enum logic [2:0] {
    IDLE,
    POP,
    DISPATCH,
    WAIT_ACK,
    WAIT_RELEASE,
    HALTED
  } state_e;

  state_e              state;
  dla_isa_pkg::instr_u instr_q; // word under decode
  logic                ack_hit;
  logic                ack_busy;

  assign o_pop    = (state == POP);
  assign ack_hit  = (o_req_feat & i_ack_feat) | (o_req_par & i_ack_par) |
                    (o_req_scale & i_ack_scale);
  assign ack_busy = i_ack_feat | i_ack_par | i_ack_scale;

  ////////////////////////////////////////////////////////////
  // decode, job and cfg held stable while req is up
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (state == POP)
      instr_q <= i_instr;
    if (state == DISPATCH) begin
      o_job.src_addr <= instr_q.xfer.src_addr;
      o_job.dst_addr <= instr_q.xfer.dst_addr;
      o_job.count    <= instr_q.xfer.count;
      o_job.target   <= instr_q.xfer.target;
      if (instr_q.cfg.opcode == dla_isa_pkg::OP_CONFIG) begin
        o_cfg.lane_sel <= instr_q.cfg.lane_sel; // cfg view of the same word
        o_cfg.shift    <= instr_q.cfg.shift;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // dispatch fsm, four-phase req/ack to one unit at a time
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state       <= IDLE;
      o_req_feat  <= 1'b0;
      o_req_par   <= 1'b0;
      o_req_scale <= 1'b0;
      o_cfg_wr    <= 1'b0;
      o_done      <= 1'b0;
    end else begin
      o_cfg_wr <= 1'b0; // single cycle strobe
      case (state)
        IDLE:     if (i_acc_enable && !i_empty) state <= POP;
        POP:      state <= DISPATCH;
        DISPATCH: begin
          state <= WAIT_ACK;
          case (instr_q.xfer.opcode)
            dla_isa_pkg::OP_LOAD_F: o_req_feat  <= 1'b1;
            dla_isa_pkg::OP_LOAD_P: o_req_par   <= 1'b1;
            dla_isa_pkg::OP_SCALE:  o_req_scale <= 1'b1;
            dla_isa_pkg::OP_CONFIG: begin
              o_cfg_wr <= 1'b1;
              state    <= IDLE;
            end
            dla_isa_pkg::OP_HALT: begin
              o_done <= 1'b1;
              state  <= HALTED;
            end
            default:  state <= IDLE; // unknown word skipped
          endcase
        end
        WAIT_ACK: if (ack_hit) begin
          o_req_feat  <= 1'b0;
          o_req_par   <= 1'b0;
          o_req_scale <= 1'b0;
          state       <= WAIT_RELEASE;
        end
        WAIT_RELEASE: if (!ack_busy) state <= IDLE; // unit let go
        HALTED:   state <= HALTED; // only reset leaves
        default:  state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* instr_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                                  clk,
  input  wire                                  i_rst,
  input  wire                                  i_push,
  input  dla_isa_pkg::instr_u                  i_push_data,
  input  wire                                  i_pop,
  output dla_isa_pkg::instr_u                  o_pop_data,
  output logic                                 o_empty,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]      o_level
);

  localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int LW = $clog2(FIFO_DEPTH + 1);

  dla_isa_pkg::instr_u mem [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr, rd_ptr;
  logic          do_push, do_pop;

  assign do_push    = i_push && (o_level != LW'(FIFO_DEPTH)); // drop on overflow
  assign do_pop     = i_pop && !o_empty;
  assign o_empty    = (o_level == '0);
  assign o_pop_data = mem[rd_ptr]; // head visible, pop next cycle after push

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= i_push_data;
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_level <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        o_level <= o_level + 1'b1;
      else if (do_pop && !do_push)
        o_level <= o_level - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* instr_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_fetch #(
  parameter int FIFO_DEPTH = 8,
  parameter int IMEM_AW    = 16
) (
  input  wire                                  clk,
  input  wire                                  i_rst,
  input  wire                                  i_run,
  input  wire  [$clog2(FIFO_DEPTH+1)-1:0]      i_fifo_level,
  output logic [IMEM_AW-1:0]                   o_instr_addr,
  output logic                                 o_instr_rd_en,
  input  wire  [dla_isa_pkg::INSTR_W-1:0]      i_instr_data,
  output logic                                 o_push,
  output logic [dla_isa_pkg::INSTR_W-1:0]      o_push_data
);

  localparam int LW = $clog2(FIFO_DEPTH + 1);

  logic [LW:0] in_use; // fifo words plus words not yet counted
  logic        can_rd;

  // a read in this cycle and a push in this cycle are both unseen by the level
  assign in_use = {1'b0, i_fifo_level} + (LW+1)'(o_instr_rd_en) + (LW+1)'(o_push);
  assign can_rd = i_run && (in_use < FIFO_DEPTH);

  assign o_push_data = i_instr_data; // memory data is valid the cycle after rd_en

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_instr_rd_en <= 1'b0;
      o_push        <= 1'b0;
      o_instr_addr  <= '0; // program starts at word 0
    end else begin
      o_instr_rd_en <= can_rd;
      o_push        <= o_instr_rd_en; // returning word goes to the fifo
      if (o_instr_rd_en)
        o_instr_addr <= o_instr_addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* dla_dp_pkg.sv */
`default_nettype none

package dla_dp_pkg;

  localparam int FEATURE_W = 16;
  localparam int SCALER_W  = 16;
  localparam int BIAS_W    = 32;
  localparam int RESULT_W  = FEATURE_W + SCALER_W;
  localparam int TN        = 8;   // lanes per feature word
  localparam int FBUS_W    = 128;
  localparam int WBUS_W    = 64;
  localparam int EXT_AW    = 16;  // external bus word address
  localparam int CNT_W     = 8;
  localparam int BUF_AW    = 8;
  localparam int BUF_DEPTH = 1 << BUF_AW;

  typedef logic [RESULT_W-1:0] result_t;

  // addr msb routes parameter writes, 0 scaler / 1 bias
  typedef struct packed {
    logic              en;
    logic [BUF_AW:0]   addr;
    logic [FBUS_W-1:0] data; // narrow buffers take the low bits
  } buf_wr_t;

  typedef struct packed {
    logic [2:0] lane_sel;
    logic [4:0] shift;
  } cfg_t;

  typedef struct packed {
    logic [EXT_AW-1:0] src_addr;
    logic [BUF_AW-1:0] dst_addr;
    logic [CNT_W-1:0]  count;
    logic              target;
  } job_t;

endpackage

`default_nettype wire

/* dla_isa_pkg.sv */
`default_nettype none

package dla_isa_pkg;

  localparam int INSTR_W = 64;

  // opcode 0 is left free and skipped by the sequencer
  typedef enum logic [3:0] {
    OP_LOAD_F = 4'h1, // feature bus to feature buffer
    OP_LOAD_P = 4'h2, // weight bus to scaler or bias buffer
    OP_CONFIG = 4'h3, // lane select and shift
    OP_SCALE  = 4'h4, // stream buffers through the multiply-add
    OP_HALT   = 4'hf  // end of program
  } opcode_e;

  // load and scale view
  typedef struct packed {
    opcode_e     opcode;   // 63:60
    logic        target;   // 59, 0 scaler / 1 bias
    logic [15:0] src_addr; // 58:43 external word address
    logic [7:0]  dst_addr; // 42:35 buffer index
    logic [7:0]  count;    // 34:27 entries minus one
    logic [26:0] pad;
  } xfer_instr_t;

  // config view
  typedef struct packed {
    opcode_e     opcode;   // 63:60
    logic [2:0]  lane_sel; // 59:57
    logic [4:0]  shift;    // 56:52
    logic [51:0] pad;
  } cfg_instr_t;

  // one word, two decodes, opcode common to both
  typedef union packed {
    xfer_instr_t xfer;
    cfg_instr_t  cfg;
  } instr_u;

endpackage

`default_nettype wire
